//--- Bender.yml
package:
  name: processorci

sources:
  - src/ci_pkg.sv
  - src/core_bus_if.sv
  - src/uart_rx.sv
  - src/uart_tx.sv
  - src/ci_controller.sv
  - src/checksum_core.sv
  - src/processorci_top.sv
  - target: simulation
    files:
      - dv/ci_controller_assertions.sv
      - dv/tb_processorci.sv

//--- dv/ci_cases.txt
# op addr data expect; W write, R read with expected word, S start, H hold, X raw opcode in data
# F fills words 1..addr from the LFSR and writes data as N to word 0, C reads addr as the sum
W 05 0000a5a5 06
R 05 00000000 0000a5a5
W 47 12345678 06
R 07 00000000 12345678
R 47 00000000 12345678
X 00 0000003f 15
X 00 00000000 15
R 05 00000000 0000a5a5
W 3f deadbeef 06
F 10 00000010 06
R 3f 00000000 deadbeef
S 00 00000000 06
C 3f 00000000 00000000
H 00 00000000 06
W 3f 0badf00d 06
R 3f 00000000 0badf00d
F 05 00000005 06
S 00 00000000 06
C 3f 00000000 00000000
H 00 00000000 06
F 3e 00000064 06
S 00 00000000 06
C 3f 00000000 00000000

//--- dv/ci_controller_assertions.sv
`timescale 1ns/1ns

module ci_controller_assertions (
    input logic sys_clk,
    input logic rst_n_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic core_rst_i
);

    int unsigned failures = 0;

    // Host access delays a core request by one cycle at most
    ack_answers_request: assert property (@(posedge sys_clk)
        disable iff (!rst_n_i || core_rst_i)
        (cyc_i && stb_i) |-> ##[0:1] ack_i)
        else begin
            failures++;
            $error("core request not acknowledged within one cycle");
        end

    ack_single_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
        else begin
            failures++;
            $error("ack high for two cycles");
        end

    // Held core must stay off the bus
    no_cyc_in_hold: assert property (@(posedge sys_clk) disable iff (!rst_n_i)
        core_rst_i |-> !cyc_i)
        else begin
            failures++;
            $error("cyc high while the core is held in reset");
        end

endmodule

bind ci_controller ci_controller_assertions u_ctrl_assertions (
    .sys_clk    (sys_clk),
    .rst_n_i    (rst_n_i),
    .cyc_i      (bus.cyc),
    .stb_i      (bus.stb),
    .ack_i      (bus.ack),
    .core_rst_i (core_rst_o)
);

//--- dv/tb_processorci.sv
`timescale 1ns/1ns

module tb_processorci import ci_pkg::*; ();

    localparam int CLKS_PER_BIT = 8;
    localparam int MEM_WORDS    = 64;
    localparam int REPLY_WAIT   = 16 * CLKS_PER_BIT;  // Longer than one full frame

    logic        sys_clk;
    logic        rst_n_i;
    logic        rx_i;
    logic        tx_o;
    byte_t       reply_q [$];
    byte_t       case_op [$];
    int          case_addr [$];
    word_t       case_data [$];
    word_t       case_exp [$];
    word_t       model_mem [MEM_WORDS];
    logic [31:0] lfsr_state = 32'h71d0;
    int          mismatches = 0;
    int          other_errors = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    processorci_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .MEM_WORDS    (MEM_WORDS)
    ) dut_i (
        .sys_clk (sys_clk),
        .rst_n_i (rst_n_i),
        .rx_i    (rx_i),
        .tx_o    (tx_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    // Fibonacci taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge sys_clk);
            rx_i = frame[i];
            repeat (CLKS_PER_BIT - 1) @(negedge sys_clk);
        end
    endtask

    // Called half a cycle after the start edge, samples near each bit centre
    task automatic capture_frame(output byte_t b, output logic framed);
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge sys_clk);
        framed = !tx_o;
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge sys_clk);
            b[i] = tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        framed = framed && tx_o;
    endtask

    initial begin
        byte_t b;
        logic  framed;
        forever begin
            @(negedge sys_clk);
            if (rst_n_i === 1'b1 && tx_o === 1'b0) begin
                capture_frame(b, framed);
                if (framed) begin
                    reply_q.push_back(b);
                end else begin
                    $display("Broken frame on tx_o, start or stop bit wrong");
                    other_errors++;
                end
            end
        end
    end

    task automatic receive_byte(output byte_t b);
        int waited;
        waited = 0;
        while (reply_q.size() == 0 && waited < REPLY_WAIT) begin
            @(negedge sys_clk);
            waited++;
        end
        b = '0;
        if (reply_q.size() == 0) begin
            $display("No start bit on tx_o within %0d cycles", REPLY_WAIT);
            other_errors++;
        end else begin
            b = reply_q.pop_front();
        end
    endtask

    task automatic write_word(input int addr, input word_t data, input byte_t exp);
        byte_t r;
        send_byte(CMD_WRITE);
        send_byte(byte_t'(addr));
        for (int i = 0; i < 4; i++) begin
            send_byte(data[8*i +: 8]);  // LSB first
        end
        receive_byte(r);
        check_byte("write_reply", r, exp);
        model_mem[addr % MEM_WORDS] = data;
    endtask

    task automatic read_word(input int addr, output word_t w);
        byte_t r;
        send_byte(CMD_READ);
        send_byte(byte_t'(addr));
        for (int i = 0; i < 4; i++) begin
            receive_byte(r);
            w[8*i +: 8] = r;
        end
    endtask

    task automatic single_command(input byte_t op, input byte_t exp);
        byte_t r;
        send_byte(op);
        receive_byte(r);
        check_byte("cmd_reply", r, exp);
    endtask

    task automatic run_case(input byte_t op, input int addr, input word_t data, input word_t exp);
        word_t w;
        word_t sum;
        int    n;
        case (op)
            "W": write_word(addr, data, exp[7:0]);
            "R": begin
                read_word(addr, w);
                check_word($sformatf("mem[%0d]", addr), w, exp);
            end
            "S": single_command(CMD_START, exp[7:0]);
            "H": single_command(CMD_HOLD, exp[7:0]);
            "X": single_command(data[7:0], exp[7:0]);
            "F": begin
                for (int i = 1; i <= addr; i++) begin
                    random_word(w);
                    write_word(i, w, exp[7:0]);
                end
                write_word(0, data, exp[7:0]);  // Count goes last
            end
            "C": begin
                // Words 1..N, N capped at MEM_WORDS-2
                n   = (model_mem[0] > MEM_WORDS - 2) ? MEM_WORDS - 2 : int'(model_mem[0]);
                sum = '0;
                for (int i = 1; i <= n; i++) begin
                    sum += model_mem[i];
                end
                read_word(addr, w);
                check_word("sum_word", w, sum);
                model_mem[MEM_WORDS - 1] = sum;
            end
            default: begin
                $display("Unknown operation 0x%02h in the case file", op);
                other_errors++;
            end
        endcase
    endtask

    task automatic load_cases(output bit ok);
        int    fd;
        string line;
        byte_t op;
        int    addr;
        word_t data;
        word_t exp;
        fd = $fopen("dv/ci_cases.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%c %h %h %h", op, addr, data, exp) == 4 && op != "#") begin
                    case_op.push_back(op);
                    case_addr.push_back(addr);
                    case_data.push_back(data);
                    case_exp.push_back(exp);
                end
            end
            $fclose(fd);
        end
    endtask

    // Host bytes plus reply bytes over the whole case list
    function automatic int case_bytes();
        int total;
        total = 0;
        foreach (case_op[i]) begin
            case (case_op[i])
                "W":      total += 7;
                "R", "C": total += 6;
                "F":      total += (case_addr[i] + 1) * 7;
                default:  total += 2;
            endcase
        end
        return total;
    endfunction

    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge sys_clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the run did not finish", cycle_limit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        bit cases_ok;
        int total_errors;
        rst_n_i = 1'b0;
        rx_i    = 1'b1;
        foreach (model_mem[i]) begin
            model_mem[i] = '0;
        end
        load_cases(cases_ok);
        if (!cases_ok) begin
            $display("Cannot open the case file dv/ci_cases.txt");
            $display("Checks failed");
            $finish;
        end else begin
            cycle_limit = case_bytes() * 10 * CLKS_PER_BIT + case_bytes() * 8 + 500;
            repeat (4) @(negedge sys_clk);
            rst_n_i = 1'b1;
            repeat (2) @(negedge sys_clk);
            foreach (case_op[i]) begin
                run_case(case_op[i], case_addr[i], case_data[i], case_exp[i]);
            end
            total_errors = mismatches + other_errors
                         + dut_i.u_ci_controller.u_ctrl_assertions.failures;
            $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                     mismatches, other_errors,
                     dut_i.u_ci_controller.u_ctrl_assertions.failures);
            if (total_errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

//--- src/checksum_core.sv
`timescale 1ns/1ns

module checksum_core import ci_pkg::*; #(
    parameter int MEM_WORDS = 64
) (
    input  logic       sys_clk,
    input  logic       rst_n_i,
    input  logic       core_rst_i,
    core_bus_if.master bus
);

    // Words 1..MEM_WORDS-2 are data, the last word takes the sum
    localparam word_t MAX_COUNT = word_t'(MEM_WORDS - 2);
    localparam addr_t SUM_ADDR  = addr_t'(MEM_WORDS - 1);

    core_state_e state_q;
    logic        rst_core_n;
    logic        cyc_q;
    logic        stb_q;
    word_t       count_q;
    addr_t       idx_q;
    word_t       sum_q;

    // Host hold acts like a power-on reset of the core
    assign rst_core_n = rst_n_i & ~core_rst_i;

    assign bus.cyc   = cyc_q;
    assign bus.stb   = stb_q;
    assign bus.we    = (state_q == CORE_WRITE_SUM);
    assign bus.wdata = sum_q;

    always_comb begin
        case (state_q)
            CORE_READ_WORD: bus.addr = idx_q;
            CORE_WRITE_SUM: bus.addr = SUM_ADDR;
            default:        bus.addr = '0;  // Count lives in word 0
        endcase
    end

    always_ff @(posedge sys_clk or negedge rst_core_n) begin
        if (!rst_core_n) begin
            state_q <= CORE_READ_CNT;
            cyc_q   <= 1'b0;
            stb_q   <= 1'b0;
            count_q <= '0;
            idx_q   <= '0;
            sum_q   <= '0;
        end else if (state_q != CORE_DONE) begin
            if (!stb_q) begin
                cyc_q <= 1'b1;
                stb_q <= 1'b1;  // Request for the current state
            end else if (bus.ack) begin
                stb_q <= 1'b0;
                case (state_q)
                    CORE_READ_CNT: begin
                        count_q <= (bus.rdata > MAX_COUNT) ? MAX_COUNT : bus.rdata;
                        idx_q   <= addr_t'(1);
                        if (bus.rdata == '0) begin
                            state_q <= CORE_WRITE_SUM;  // Empty block
                        end else begin
                            state_q <= CORE_READ_WORD;
                        end
                    end
                    CORE_READ_WORD: begin
                        sum_q <= sum_q + bus.rdata;  // Wraps modulo 2^32
                        idx_q <= idx_q + 1;
                        if (idx_q == count_q) begin
                            state_q <= CORE_WRITE_SUM;
                        end
                    end
                    CORE_WRITE_SUM: begin
                        cyc_q   <= 1'b0;
                        state_q <= CORE_DONE;
                    end
                    default: begin
                        state_q <= CORE_DONE;
                    end
                endcase
            end
        end
    end

endmodule

//--- src/ci_controller.sv
`timescale 1ns/1ns

module ci_controller import ci_pkg::*; #(
    parameter int MEM_WORDS = 64
) (
    input  logic      sys_clk,
    input  logic      rst_n_i,
    input  byte_t     rx_byte_i,
    input  logic      rx_valid_i,
    output byte_t     tx_byte_o,
    output logic      tx_start_o,
    input  logic      tx_busy_i,
    output logic      core_rst_o,
    core_bus_if.slave bus
);

    localparam int AW = $clog2(MEM_WORDS);

    ctrl_state_e   state_q;
    byte_t         opcode_q;
    byte_t         addr_q;
    word_t         data_q;
    logic [1:0]    byte_cnt_q;
    word_t         rsp_word_q;
    logic [1:0]    rsp_left_q;  // Reply bytes after the current one

    word_t         mem [MEM_WORDS];
    logic [AW-1:0] mem_idx;
    word_t         mem_rdata;
    word_t         mem_wdata;
    logic          mem_we;
    logic          host_access;
    logic          send_byte;

    // Host owns the memory port for one cycle, the core waits
    assign host_access = (state_q == CTRL_ACCESS);

    assign bus.ack   = bus.cyc & bus.stb & ~host_access;
    assign mem_idx   = host_access ? AW'(addr_q) : AW'(bus.addr);  // Address wraps
    assign mem_rdata = mem[mem_idx];
    assign bus.rdata = mem_rdata;
    assign mem_we    = host_access ? (opcode_q == CMD_WRITE) : (bus.ack & bus.we);
    assign mem_wdata = host_access ? data_q : bus.wdata;

    // tx_busy rises one cycle late, so skip the cycle of our own strobe
    assign send_byte = (state_q == CTRL_REPLY) && !tx_busy_i && !tx_start_o;

    always_ff @(posedge sys_clk) begin
        if (mem_we) begin
            mem[mem_idx] <= mem_wdata;
        end
    end

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= CTRL_IDLE;
            byte_cnt_q <= '0;
            rsp_left_q <= '0;
            tx_start_o <= 1'b0;
            core_rst_o <= 1'b1;  // Core held until the first S
        end else begin
            tx_start_o <= send_byte;
            case (state_q)
                CTRL_IDLE: begin
                    if (rx_valid_i) begin
                        if (rx_byte_i == CMD_WRITE || rx_byte_i == CMD_READ) begin
                            state_q <= CTRL_ADDR;
                        end else begin
                            state_q <= CTRL_ACCESS;  // No operands
                        end
                    end
                end
                CTRL_ADDR: begin
                    if (rx_valid_i) begin
                        byte_cnt_q <= '0;
                        state_q    <= (opcode_q == CMD_WRITE) ? CTRL_DATA : CTRL_ACCESS;
                    end
                end
                CTRL_DATA: begin
                    if (rx_valid_i) begin
                        byte_cnt_q <= byte_cnt_q + 2'd1;
                        if (byte_cnt_q == 2'd3) begin
                            state_q <= CTRL_ACCESS;
                        end
                    end
                end
                CTRL_ACCESS: begin
                    rsp_left_q <= (opcode_q == CMD_READ) ? 2'd3 : 2'd0;
                    if (opcode_q == CMD_START) begin
                        core_rst_o <= 1'b0;
                    end
                    if (opcode_q == CMD_HOLD) begin
                        core_rst_o <= 1'b1;
                    end
                    state_q <= CTRL_REPLY;
                end
                CTRL_REPLY: begin
                    if (send_byte) begin
                        rsp_left_q <= rsp_left_q - 2'd1;
                        if (rsp_left_q == 2'd0) begin
                            state_q <= CTRL_IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= CTRL_IDLE;
                end
            endcase
        end
    end

    // Command operands and reply data
    always_ff @(posedge sys_clk) begin
        if (rx_valid_i) begin
            if (state_q == CTRL_IDLE) begin
                opcode_q <= rx_byte_i;
            end
            if (state_q == CTRL_ADDR) begin
                addr_q <= rx_byte_i;
            end
            if (state_q == CTRL_DATA) begin
                data_q <= {rx_byte_i, data_q[31:8]};  // LSB first
            end
        end
        if (host_access) begin
            case (opcode_q)
                CMD_READ: begin
                    rsp_word_q <= mem_rdata;
                end
                CMD_WRITE, CMD_START, CMD_HOLD: begin
                    rsp_word_q <= {24'h0, RSP_ACK};
                end
                default: begin
                    rsp_word_q <= {24'h0, RSP_NAK};
                end
            endcase
        end else if (send_byte) begin
            tx_byte_o  <= rsp_word_q[7:0];
            rsp_word_q <= rsp_word_q >> 8;
        end
    end

endmodule

//--- src/ci_pkg.sv
package ci_pkg;

    typedef logic [31:0] word_t;  // Bus data and memory words
    typedef logic [31:0] addr_t;  // Word address, low bits decoded
    typedef logic [7:0]  byte_t;  // One UART character

    // Host opcodes
    localparam byte_t CMD_WRITE = 8'h57;  // "W"
    localparam byte_t CMD_READ  = 8'h52;  // "R"
    localparam byte_t CMD_START = 8'h53;  // "S"
    localparam byte_t CMD_HOLD  = 8'h48;  // "H"

    // Reply codes
    localparam byte_t RSP_ACK = 8'h06;
    localparam byte_t RSP_NAK = 8'h15;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_ADDR,
        CTRL_DATA,
        CTRL_ACCESS,
        CTRL_REPLY
    } ctrl_state_e;

    typedef enum logic [1:0] {
        CORE_READ_CNT,
        CORE_READ_WORD,
        CORE_WRITE_SUM,
        CORE_DONE
    } core_state_e;

endpackage

//--- src/core_bus_if.sv
`timescale 1ns/1ns

interface core_bus_if import ci_pkg::*; ();

    logic  cyc;
    logic  stb;
    logic  we;     // 1 = write
    addr_t addr;
    word_t wdata;
    word_t rdata;  // Valid together with ack
    logic  ack;

    // Core side
    modport master (output cyc, stb, we, addr, wdata, input rdata, ack);

    // Memory side
    modport slave (input cyc, stb, we, addr, wdata, output rdata, ack);

endinterface

//--- src/processorci_top.sv
`timescale 1ns/1ns

module processorci_top import ci_pkg::*; #(
    parameter int CLKS_PER_BIT = 8,
    parameter int MEM_WORDS    = 64
) (
    input  logic sys_clk,
    input  logic rst_n_i,
    input  logic rx_i,
    output logic tx_o
);

    byte_t rx_byte;
    logic  rx_valid;
    byte_t tx_byte;
    logic  tx_start;
    logic  tx_busy;
    logic  core_rst;

    core_bus_if core_bus ();

    // Host side
    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_rx (
        .sys_clk    (sys_clk),
        .rst_n_i    (rst_n_i),
        .rx_i       (rx_i),
        .rx_byte_o  (rx_byte),
        .rx_valid_o (rx_valid)
    );

    ci_controller #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ci_controller (
        .sys_clk    (sys_clk),
        .rst_n_i    (rst_n_i),
        .rx_byte_i  (rx_byte),
        .rx_valid_i (rx_valid),
        .tx_byte_o  (tx_byte),
        .tx_start_o (tx_start),
        .tx_busy_i  (tx_busy),
        .core_rst_o (core_rst),
        .bus        (core_bus.slave)
    );

    // Core space
    checksum_core #(
        .MEM_WORDS (MEM_WORDS)
    ) u_checksum_core (
        .sys_clk    (sys_clk),
        .rst_n_i    (rst_n_i),
        .core_rst_i (core_rst),
        .bus        (core_bus.master)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .sys_clk    (sys_clk),
        .rst_n_i    (rst_n_i),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .tx_o       (tx_o),
        .tx_busy_o  (tx_busy)
    );

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ns

module uart_rx import ci_pkg::*; #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic  sys_clk,
    input  logic  rst_n_i,
    input  logic  rx_i,
    output byte_t rx_byte_o,
    output logic  rx_valid_o
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    logic          rx_meta_q;
    logic          rx_sync_q;
    logic          rx_prev_q;
    logic          active_q;
    logic [CW-1:0] clk_cnt_q;
    logic [3:0]    bit_idx_q;  // 0 start, 1..8 data, 9 stop
    logic          sample;
    byte_t         data_q;

    assign sample    = active_q && (clk_cnt_q == '0);
    assign rx_byte_o = data_q;

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta_q  <= 1'b1;  // Line idles high
            rx_sync_q  <= 1'b1;
            rx_prev_q  <= 1'b1;
            active_q   <= 1'b0;
            clk_cnt_q  <= '0;
            bit_idx_q  <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_meta_q  <= rx_i;
            rx_sync_q  <= rx_meta_q;
            rx_prev_q  <= rx_sync_q;
            rx_valid_o <= 1'b0;
            if (!active_q) begin
                if (rx_prev_q && !rx_sync_q) begin
                    // Falling edge, wait half a bit to reach the centre
                    active_q  <= 1'b1;
                    clk_cnt_q <= CW'(CLKS_PER_BIT / 2 - 1);
                    bit_idx_q <= '0;
                end
            end else if (sample) begin
                clk_cnt_q <= CW'(CLKS_PER_BIT - 1);
                bit_idx_q <= bit_idx_q + 4'd1;
                if (bit_idx_q == 4'd0 && rx_sync_q) begin
                    active_q <= 1'b0;  // Glitch, not a real start bit
                end else if (bit_idx_q == 4'd9) begin
                    active_q   <= 1'b0;
                    rx_valid_o <= rx_sync_q;  // Framing error drops the byte
                end
            end else begin
                clk_cnt_q <= clk_cnt_q - 1'b1;
            end
        end
    end

    // LSB arrives first
    always_ff @(posedge sys_clk) begin
        if (sample && bit_idx_q >= 4'd1 && bit_idx_q <= 4'd8) begin
            data_q <= {rx_sync_q, data_q[7:1]};
        end
    end

endmodule

//--- src/uart_tx.sv
`timescale 1ns/1ns

module uart_tx import ci_pkg::*; #(
    parameter int CLKS_PER_BIT = 8
) (
    input  logic  sys_clk,
    input  logic  rst_n_i,
    input  logic  tx_start_i,
    input  byte_t tx_byte_i,
    output logic  tx_o,
    output logic  tx_busy_o
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    logic [9:0]    frame_q;    // Stop, data, start
    logic [CW-1:0] clk_cnt_q;
    logic [3:0]    bit_cnt_q;
    logic          bit_end;

    assign bit_end = tx_busy_o && (clk_cnt_q == '0);
    assign tx_o    = tx_busy_o ? frame_q[0] : 1'b1;

    always_ff @(posedge sys_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_busy_o <= 1'b0;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else if (!tx_busy_o) begin
            if (tx_start_i) begin
                tx_busy_o <= 1'b1;
                clk_cnt_q <= CW'(CLKS_PER_BIT - 1);
                bit_cnt_q <= '0;
            end
        end else if (bit_end) begin
            clk_cnt_q <= CW'(CLKS_PER_BIT - 1);
            if (bit_cnt_q == 4'd9) begin
                tx_busy_o <= 1'b0;  // Stop bit done
            end else begin
                bit_cnt_q <= bit_cnt_q + 4'd1;
            end
        end else begin
            clk_cnt_q <= clk_cnt_q - 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!tx_busy_o && tx_start_i) begin
            frame_q <= {1'b1, tx_byte_i, 1'b0};
        end else if (bit_end) begin
            frame_q <= {1'b1, frame_q[9:1]};
        end
    end

endmodule

//--- vlog.f
src/ci_pkg.sv
src/core_bus_if.sv
src/uart_rx.sv
src/uart_tx.sv
src/ci_controller.sv
src/checksum_core.sv
src/processorci_top.sv
dv/ci_controller_assertions.sv
dv/tb_processorci.sv
